// ==== design/m92_board_pkg.sv ====
// Port map and switch widths of the main-board I/O block; port 0x08 sound latch is not decoded
package m92_board_pkg;

    // ==================================================
    // I/O port addresses (even byte of each word port)
    // ==================================================
    typedef enum logic [7:0] {
        port_switch_p1_p2 = 8'h00,
        port_flags        = 8'h02,
        port_dip          = 8'h04,
        port_switch_p3_p4 = 8'h06,
        port_bank         = 8'h20
    } io_port_e;

    // ==================================================
    // Data types
    // ==================================================
    typedef logic [7:0]  io_byte_t;    // CPU I/O bus byte
    typedef logic [15:0] io_word_t;    // Port word before byte select
    typedef logic [3:0]  bank_sel_t;   // ROM bank number

    // ==================================================
    // Input widths
    // ==================================================
    localparam int PLAYER_W = 10;      // Directions plus six buttons
    localparam int DIP_W    = 24;

    // System flags register fields
    localparam int SYS_COIN0_BIT   = 0;
    localparam int SYS_COIN1_BIT   = 1;
    localparam int SYS_SOFT_NL_BIT = 2;  // Active low in the register

    // Screen flip DIP
    localparam int DIP_NL_BIT = 8;

endpackage

// ==== design/m92_video_pkg.sv ====
// Sprite buffer geometry and video control bits; four banks of 2048 words fixed by the board
package m92_video_pkg;

    // ==================================================
    // Buffer RAM geometry
    // ==================================================
    localparam int BUF_AW    = 11;
    localparam int BUF_DEPTH = 1 << BUF_AW;
    localparam int BUF_DW    = 16;
    localparam int BUF_BANKS = 4;

    typedef logic [BUF_AW-1:0]            buf_addr_t;
    typedef logic [BUF_DW-1:0]            buf_word_t;
    typedef logic [$clog2(BUF_BANKS)-1:0] bank_idx_t;
    typedef logic [15:0]                  vid_ctrl_t;

    // ==================================================
    // Video control bits used for the bank choice
    // ==================================================
    localparam int VC_LO_IDLE_BIT = 0;  // Lower half, DMA idle
    localparam int VC_HI_IDLE_LO  = 1;
    localparam int VC_HI_IDLE_HI  = 2;
    localparam int VC_LO_DMA_BIT  = 3;  // Lower half, DMA running
    localparam int VC_HI_DMA_LO   = 4;
    localparam int VC_HI_DMA_HI   = 5;

endpackage

// ==== design/m92_io_ports.sv ====
// Read path is purely combinational; port 0x20 is write-only and undecoded ports read 0xff
`timescale 1ns/1ns

module m92_io_ports import m92_board_pkg::*; (
    input  logic                clk_sys,
    input  logic                reset_n,

    input  logic                kick_harness,   // Kick harness wiring for extra buttons
    input  logic [3:0]          coin,
    input  logic [3:0]          start_buttons,
    input  logic [PLAYER_W-1:0] p1_input,
    input  logic [PLAYER_W-1:0] p2_input,
    input  logic [PLAYER_W-1:0] p3_input,
    input  logic [PLAYER_W-1:0] p4_input,
    input  logic [DIP_W-1:0]    dip_sw,
    input  logic                dma_busy,

    input  io_byte_t            io_addr,
    input  logic                io_wr,
    input  io_byte_t            io_wdata,
    output io_byte_t            io_rdata,

    output logic [1:0]          coin_counter,
    output logic                nl,
    output bank_sel_t           bank_select
);

    // Standard byte layout of one player's switches
    function automatic io_byte_t switch_byte(
        input logic [PLAYER_W-1:0] p,
        input logic                bit5,
        input logic                bit4
    );
        return {p[4], p[5], bit5, bit4, p[3:0]};
    endfunction

    io_byte_t                 switches_p1;
    io_byte_t                 switches_p2;
    io_byte_t                 switches_p3;
    io_byte_t                 switches_p4;
    io_word_t                 switches_p1_p2;
    io_word_t                 switches_p3_p4;
    io_word_t                 flags_word;
    io_word_t                 port_word;
    io_byte_t                 port_base;
    logic [SYS_SOFT_NL_BIT:0] sys_flags;   // Only the coin and flip fields are kept

    // ==================================================
    // Switch mapping
    // ==================================================
    // Kick harness puts button 3 of P1/P2 on bit 5
    assign switches_p1 = switch_byte(p1_input, kick_harness & p1_input[6], 1'b0);
    assign switches_p2 = switch_byte(p2_input, kick_harness & p2_input[6], 1'b0);

    assign switches_p3 = kick_harness ? 8'h00
                                      : switch_byte(p3_input, coin[2], start_buttons[2]);

    // P3/P4 port carries the P1/P2 kick buttons on that harness
    assign switches_p4 = kick_harness
                       ? {p2_input[9:7], 1'b0, p1_input[9:7], 1'b0}
                       : switch_byte(p4_input, coin[3], start_buttons[3]);

    assign switches_p1_p2 = {~switches_p2, ~switches_p1};
    assign switches_p3_p4 = {~switches_p4, ~switches_p3};

    // Bits 6:4 are TEST, R and a spare, all tied high
    assign flags_word = {~dip_sw[23:16], ~dma_busy, 3'b111,
                         ~coin[1:0], ~start_buttons[1:0]};

    // ==================================================
    // Read multiplexer
    // ==================================================
    assign port_base = {io_addr[7:1], 1'b0};

    always_comb begin
        case (port_base)
            port_switch_p1_p2: port_word = switches_p1_p2;
            port_flags:        port_word = flags_word;
            port_dip:          port_word = ~dip_sw[15:0];
            port_switch_p3_p4: port_word = switches_p3_p4;
            default:           port_word = 16'hffff;
        endcase
    end

    assign io_rdata = io_addr[0] ? port_word[15:8] : port_word[7:0];

    // ==================================================
    // Write registers
    // ==================================================
    always_ff @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) begin
            sys_flags   <= '0;
            bank_select <= '0;
        end else if (io_wr) begin
            if (io_addr == port_flags) begin
                sys_flags <= io_wdata[SYS_SOFT_NL_BIT:0];
            end
            if (io_addr == port_bank) begin
                bank_select <= io_wdata[$bits(bank_sel_t)-1:0];
            end
        end
    end

    assign coin_counter = {sys_flags[SYS_COIN1_BIT], sys_flags[SYS_COIN0_BIT]};

    // Soft flip is stored inverted, DIP switch is active low
    assign nl = ~sys_flags[SYS_SOFT_NL_BIT] ^ ~dip_sw[DIP_NL_BIT];

endmodule

// ==== design/buffer_bank_select.sv ====
// Bank choice is combinational from address bit 10 and dma_busy; only video control bits 5:0 matter
`timescale 1ns/1ns

module buffer_bank_select import m92_video_pkg::*; (
    input  logic                 clk_sys,
    input  logic                 reset_n,

    input  logic                 vid_ctrl_wr,
    input  vid_ctrl_t            vid_ctrl_wdata,

    input  buf_addr_t            buf_addr,
    input  logic                 buf_we,
    input  logic                 dma_busy,

    output bank_idx_t            bank_idx,
    output logic [BUF_BANKS-1:0] bank_we
);

    vid_ctrl_t vid_ctrl;

    always_ff @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) begin
            vid_ctrl <= '0;
        end else if (vid_ctrl_wr) begin
            vid_ctrl <= vid_ctrl_wdata;
        end
    end

    // ==================================================
    // Bank choice
    // ==================================================
    always_comb begin
        case ({buf_addr[BUF_AW-1], dma_busy})
            2'b00:   bank_idx = {1'b0, vid_ctrl[VC_LO_IDLE_BIT]};
            2'b10:   bank_idx = {vid_ctrl[VC_HI_IDLE_HI], vid_ctrl[VC_HI_IDLE_LO]};
            2'b01:   bank_idx = {1'b0, vid_ctrl[VC_LO_DMA_BIT]};
            default: bank_idx = {vid_ctrl[VC_HI_DMA_HI], vid_ctrl[VC_HI_DMA_LO]};
        endcase
    end

    // One-hot write enable into the chosen bank
    always_comb begin
        bank_we           = '0;
        bank_we[bank_idx] = buf_we;
    end

endmodule

// ==== design/buffer_bank.sv ====
// Single-port buffer RAM with asynchronous read; contents are undefined after power-up
`timescale 1ns/1ns

module buffer_bank import m92_video_pkg::*; (
    input  logic      clk_sys,
    input  buf_addr_t addr,
    input  logic      we,
    input  buf_word_t wdata,
    output buf_word_t q
);

    buf_word_t mem [BUF_DEPTH];

    always_ff @(posedge clk_sys) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    assign q = mem[addr];  // Unregistered read

endmodule

// ==== design/buffer_read_mux.sv ====
// Pure combinational select; bank_idx must come from the same cycle's address and dma_busy
`timescale 1ns/1ns

module buffer_read_mux import m92_video_pkg::*; (
    input  buf_word_t bank_q [BUF_BANKS],
    input  bank_idx_t bank_idx,
    output buf_word_t buf_rdata
);

    always_comb begin
        buf_rdata = bank_q[0];
        for (int i = 1; i < BUF_BANKS; i++) begin
            if (bank_idx == bank_idx_t'(i)) begin
                buf_rdata = bank_q[i];
            end
        end
    end

endmodule

// ==== design/m92_io_buffer.sv ====
// Single clock domain; no handshake, so every I/O, video control and buffer strobe is taken at once
`timescale 1ns/1ns

module m92_io_buffer import m92_board_pkg::*, m92_video_pkg::*; (
    input  logic                clk_sys,
    input  logic                reset_n,

    // Board inputs
    input  logic                kick_harness,
    input  logic [3:0]          coin,
    input  logic [3:0]          start_buttons,
    input  logic [PLAYER_W-1:0] p1_input,
    input  logic [PLAYER_W-1:0] p2_input,
    input  logic [PLAYER_W-1:0] p3_input,
    input  logic [PLAYER_W-1:0] p4_input,
    input  logic [DIP_W-1:0]    dip_sw,

    // CPU I/O bus
    input  io_byte_t            io_addr,
    input  logic                io_wr,
    input  io_byte_t            io_wdata,
    output io_byte_t            io_rdata,
    output logic [1:0]          coin_counter,
    output logic                nl,
    output bank_sel_t           bank_select,

    // Video control register
    input  logic                vid_ctrl_wr,
    input  vid_ctrl_t           vid_ctrl_wdata,

    // Sprite DMA side of the buffer
    input  logic                dma_busy,
    input  buf_addr_t           buf_addr,
    input  logic                buf_we,
    input  buf_word_t           buf_wdata,
    output buf_word_t           buf_rdata
);

    bank_idx_t            bank_idx;
    logic [BUF_BANKS-1:0] bank_we;
    buf_word_t            bank_q [BUF_BANKS];

    m92_io_ports u_io_ports (
        .clk_sys       (clk_sys),
        .reset_n       (reset_n),
        .kick_harness  (kick_harness),
        .coin          (coin),
        .start_buttons (start_buttons),
        .p1_input      (p1_input),
        .p2_input      (p2_input),
        .p3_input      (p3_input),
        .p4_input      (p4_input),
        .dip_sw        (dip_sw),
        .dma_busy      (dma_busy),
        .io_addr       (io_addr),
        .io_wr         (io_wr),
        .io_wdata      (io_wdata),
        .io_rdata      (io_rdata),
        .coin_counter  (coin_counter),
        .nl            (nl),
        .bank_select   (bank_select)
    );

    // ==================================================
    // Banked sprite buffer
    // ==================================================
    buffer_bank_select u_bank_select (
        .clk_sys        (clk_sys),
        .reset_n        (reset_n),
        .vid_ctrl_wr    (vid_ctrl_wr),
        .vid_ctrl_wdata (vid_ctrl_wdata),
        .buf_addr       (buf_addr),
        .buf_we         (buf_we),
        .dma_busy       (dma_busy),
        .bank_idx       (bank_idx),
        .bank_we        (bank_we)
    );

    for (genvar i = 0; i < BUF_BANKS; i++) begin : g_bank
        buffer_bank u_bank (
            .clk_sys (clk_sys),
            .addr    (buf_addr),
            .we      (bank_we[i]),
            .wdata   (buf_wdata),
            .q       (bank_q[i])
        );
    end

    buffer_read_mux u_read_mux (
        .bank_q    (bank_q),
        .bank_idx  (bank_idx),
        .buf_rdata (buf_rdata)
    );

endmodule

// ==== include/tb_ref_model.svh ====
// Import both board packages before including; a check stops the run at its first mismatch
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// ==================================================
// Stimulus source
// ==================================================
function automatic logic [31:0] xorshift(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// ==================================================
// Reference model
// ==================================================
function automatic io_byte_t ref_io_read(
    input io_byte_t            addr,
    input logic                kick,
    input logic [3:0]          coin,
    input logic [3:0]          start,
    input logic [PLAYER_W-1:0] p1,
    input logic [PLAYER_W-1:0] p2,
    input logic [PLAYER_W-1:0] p3,
    input logic [PLAYER_W-1:0] p4,
    input logic [DIP_W-1:0]    dip,
    input logic                busy
);
    io_byte_t b1;
    io_byte_t b2;
    io_byte_t b3;
    io_byte_t b4;
    io_word_t word;
    b1 = {p1[4], p1[5], kick & p1[6], 1'b0, p1[3:0]};
    b2 = {p2[4], p2[5], kick & p2[6], 1'b0, p2[3:0]};
    b3 = kick ? 8'h00 : {p3[4], p3[5], coin[2], start[2], p3[3:0]};
    b4 = kick ? {p2[9], p2[8], p2[7], 1'b0, p1[9], p1[8], p1[7], 1'b0}
              : {p4[4], p4[5], coin[3], start[3], p4[3:0]};
    case ({addr[7:1], 1'b0})
        8'h00:   word = ~{b2, b1};
        8'h02:   word = {~dip[23:16], ~busy, 3'b111, ~coin[1:0], ~start[1:0]};
        8'h04:   word = ~dip[15:0];
        8'h06:   word = ~{b4, b3};
        default: word = 16'hffff;
    endcase
    return addr[0] ? word[15:8] : word[7:0];
endfunction

function automatic logic ref_nl(input logic soft_bit, input logic dip_nl);
    return ~soft_bit ^ ~dip_nl;
endfunction

function automatic bank_idx_t ref_bank_idx(
    input logic      addr_hi,
    input logic      busy,
    input vid_ctrl_t vc
);
    if (!addr_hi) begin
        return {1'b0, busy ? vc[VC_LO_DMA_BIT] : vc[VC_LO_IDLE_BIT]};
    end
    return busy ? {vc[VC_HI_DMA_HI], vc[VC_HI_DMA_LO]}
                : {vc[VC_HI_IDLE_HI], vc[VC_HI_IDLE_LO]};
endfunction

// ==================================================
// Compare tasks
// ==================================================
task automatic report_failure(input string msg);
    $display("FAILED at %0t: %s", $time, msg);
    $display("Test FAILED");
    $fatal(1, "%s", msg);
endtask

task automatic check_io_byte(input io_byte_t got, input io_byte_t exp, input string what);
    if (got !== exp) begin
        report_failure($sformatf("%s read %h, expected %h", what, got, exp));
    end
endtask

task automatic check_bank(input bank_sel_t got, input bank_sel_t exp, input string what);
    if (got !== exp) begin
        report_failure($sformatf("%s is %h, expected %h", what, got, exp));
    end
endtask

task automatic check_buf_word(input buf_word_t got, input buf_word_t exp, input string what);
    if (got !== exp) begin
        report_failure($sformatf("%s read %h, expected %h", what, got, exp));
    end
endtask

`endif

// ==== testbench/tb_m92_io_buffer.sv ====
// Unwritten buffer words are skipped by the buffer compare; inputs change on falling edges
`timescale 1ns/1ns

module tb_m92_io_buffer
    import m92_board_pkg::*, m92_video_pkg::*;
();

    `include "tb_ref_model.svh"

    localparam int CLK_HALF    = 50;
    localparam int N_RAND      = 32;   // Random board settings per harness mode
    localparam int N_READ_ADDR = 8;
    localparam int N_TOGGLE    = 16;
    localparam int N_ROUNDS    = 16;   // Video control values in the buffer test
    localparam int N_BUF_WR    = 24;
    localparam int N_BUF_RD    = 32;   // 16 addresses at both dma_busy levels
    localparam int TEST_CYCLES = 3 + 4 + 2 * N_RAND * (1 + 2 * N_READ_ADDR) + N_TOGGLE + 14
                               + N_ROUNDS * (1 + N_BUF_WR + N_BUF_RD) + 3;
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES + 100;

    logic                clk_sys;
    logic                reset_n;
    logic                kick_harness;
    logic [3:0]          coin;
    logic [3:0]          start_buttons;
    logic [PLAYER_W-1:0] p1_input;
    logic [PLAYER_W-1:0] p2_input;
    logic [PLAYER_W-1:0] p3_input;
    logic [PLAYER_W-1:0] p4_input;
    logic [DIP_W-1:0]    dip_sw;
    io_byte_t            io_addr;
    logic                io_wr;
    io_byte_t            io_wdata;
    io_byte_t            io_rdata;
    logic [1:0]          coin_counter;
    logic                nl;
    bank_sel_t           bank_select;
    logic                vid_ctrl_wr;
    vid_ctrl_t           vid_ctrl_wdata;
    logic                dma_busy;
    buf_addr_t           buf_addr;
    logic                buf_we;
    buf_word_t           buf_wdata;
    buf_word_t           buf_rdata;

    logic [31:0]         rng_state;
    logic                check_en;
    int                  cycle_count;
    logic [2:0]          model_flags;  // Coin counters and soft flip
    bank_sel_t           model_bank;
    vid_ctrl_t           model_vc;
    buf_word_t           shadow [BUF_BANKS][BUF_DEPTH];
    io_byte_t            read_addrs [N_READ_ADDR] = '{8'h00, 8'h02, 8'h04, 8'h06,
                                                      8'h08, 8'h20, 8'h0a, 8'h7e};

    m92_io_buffer UUT (.*);

    always #(CLK_HALF) clk_sys = ~clk_sys;

    // ==================================================
    // Stimulus helpers
    // ==================================================
    function automatic logic [31:0] next_random();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    task automatic check_level(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("%s is %b, expected %b", what, got, exp));
        end
    endtask

    task automatic check_coin_counter(input logic [1:0] got, input logic [1:0] exp,
                                      input string what);
        if (got !== exp) begin
            report_failure($sformatf("%s is %b, expected %b", what, got, exp));
        end
    endtask

    task automatic step_io(input io_byte_t addr, input logic wr, input io_byte_t data);
        @(negedge clk_sys);
        io_addr     = addr;
        io_wr       = wr;
        io_wdata    = data;
        vid_ctrl_wr = 1'b0;
        buf_we      = 1'b0;
    endtask

    task automatic step_buffer(input logic busy, input buf_addr_t addr, input logic we,
                               input buf_word_t data);
        @(negedge clk_sys);
        io_wr       = 1'b0;
        vid_ctrl_wr = 1'b0;
        dma_busy    = busy;
        buf_addr    = addr;
        buf_we      = we;
        buf_wdata   = data;
    endtask

    task automatic write_vid_ctrl(input vid_ctrl_t value);
        @(negedge clk_sys);
        io_wr          = 1'b0;
        buf_we         = 1'b0;
        vid_ctrl_wr    = 1'b1;
        vid_ctrl_wdata = value;
    endtask

    task automatic randomize_board(input logic kick);
        logic [31:0] r0;
        logic [31:0] r1;
        logic [31:0] r2;
        r0 = next_random();
        r1 = next_random();
        r2 = next_random();
        @(negedge clk_sys);
        io_wr         = 1'b0;
        kick_harness  = kick;
        p1_input      = r0[9:0];
        p2_input      = r0[19:10];
        p3_input      = r0[29:20];
        p4_input      = r1[9:0];
        coin          = r1[13:10];
        start_buttons = r1[17:14];
        dma_busy      = r1[18];
        dip_sw        = r2[23:0];
    endtask

    // ==================================================
    // Model state and comparing process
    // ==================================================
    always @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) begin
            model_flags <= '0;
            model_bank  <= '0;
            model_vc    <= '0;
        end else begin
            if (io_wr && io_addr == port_flags) model_flags <= io_wdata[2:0];
            if (io_wr && io_addr == port_bank) model_bank <= io_wdata[3:0];
            if (vid_ctrl_wr) model_vc <= vid_ctrl_wdata;
            if (buf_we) begin
                shadow[ref_bank_idx(buf_addr[BUF_AW-1], dma_busy, model_vc)][buf_addr]
                    <= buf_wdata;
            end
        end
    end

    task automatic compare_outputs();
        buf_word_t exp_word;
        check_io_byte(io_rdata, ref_io_read(io_addr, kick_harness, coin, start_buttons,
                      p1_input, p2_input, p3_input, p4_input, dip_sw, dma_busy),
                      $sformatf("port %h", io_addr));
        check_coin_counter(coin_counter, model_flags[SYS_COIN1_BIT:SYS_COIN0_BIT],
                           "coin_counter");
        check_level(nl, ref_nl(model_flags[SYS_SOFT_NL_BIT], dip_sw[DIP_NL_BIT]), "nl");
        check_bank(bank_select, model_bank, "bank_select");
        exp_word = shadow[ref_bank_idx(buf_addr[BUF_AW-1], dma_busy, model_vc)][buf_addr];
        if (!$isunknown(exp_word)) begin
            check_buf_word(buf_rdata, exp_word, $sformatf("buffer %h", buf_addr));
        end
    endtask

    initial begin
        forever begin
            @(negedge clk_sys);
            #(CLK_HALF - 10);  // Just before the rising edge
            if (check_en) compare_outputs();
        end
    end

    always @(posedge clk_sys) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run timed out after %0d cycles without finishing the tests", cycle_count);
            $display("Test FAILED");
            $fatal(1, "timeout");
        end
    end

    // ==================================================
    // Test sequence
    // ==================================================
    initial begin
        clk_sys        = 1'b0;
        reset_n        = 1'b0;
        check_en       = 1'b0;
        cycle_count    = 0;
        rng_state      = 32'd27;
        kick_harness   = 1'b0;
        coin           = '0;
        start_buttons  = '0;
        p1_input       = '0;
        p2_input       = '0;
        p3_input       = '0;
        p4_input       = '0;
        dip_sw         = '0;
        io_addr        = '0;
        io_wr          = 1'b0;
        io_wdata       = '0;
        vid_ctrl_wr    = 1'b0;
        vid_ctrl_wdata = '0;
        dma_busy       = 1'b0;
        buf_addr       = '0;
        buf_we         = 1'b0;
        buf_wdata      = '0;
        repeat (3) @(posedge clk_sys);
        @(negedge clk_sys);
        reset_n  = 1'b1;
        check_en = 1'b1;

        // Reset state, then a write into bank 0
        step_io(port_switch_p1_p2, 1'b0, 8'h00);
        check_coin_counter(coin_counter, 2'b00, "coin_counter after reset");
        check_bank(bank_select, 4'h0, "bank_select after reset");
        check_level(nl, ref_nl(1'b0, dip_sw[DIP_NL_BIT]), "nl after reset");
        step_buffer(1'b0, 11'h012, 1'b1, 16'h5a3c);
        step_buffer(1'b0, 11'h012, 1'b0, 16'h0000);
        check_buf_word(UUT.bank_q[0], 16'h5a3c, "bank 0 after reset");

        // Every port at both byte halves
        for (int kick = 0; kick < 2; kick++) begin
            for (int n = 0; n < N_RAND; n++) begin
                randomize_board(kick[0]);
                for (int a = 0; a < 2 * N_READ_ADDR; a++) begin
                    step_io(read_addrs[a / 2] | io_byte_t'(a % 2), 1'b0, 8'h00);
                end
            end
        end

        // Each byte half sees both dma_busy levels
        for (int i = 0; i < N_TOGGLE; i++) begin
            step_io(port_flags | io_byte_t'((i / 2) % 2), 1'b0, 8'h00);
            dma_busy = ~dma_busy;
        end

        // Register writes show on the next cycle
        step_io(port_flags, 1'b1, 8'h07);
        step_io(port_switch_p1_p2, 1'b0, 8'h00);
        check_coin_counter(coin_counter, 2'b11, "coin_counter after write");
        check_level(nl, ref_nl(1'b1, dip_sw[DIP_NL_BIT]), "nl after write");
        step_io(port_bank, 1'b1, 8'hfb);
        step_io(port_switch_p1_p2, 1'b0, 8'h00);
        check_bank(bank_select, 4'hb, "bank_select after write");
        step_io(8'h03, 1'b1, 8'h00);
        step_io(8'h21, 1'b1, 8'h00);
        step_io(8'h04, 1'b1, 8'h00);
        step_io(port_switch_p1_p2, 1'b0, 8'h00);
        check_coin_counter(coin_counter, 2'b11, "coin_counter after other writes");
        check_bank(bank_select, 4'hb, "bank_select after other writes");
        step_io(port_flags, 1'b1, 8'h01);
        step_io(port_switch_p1_p2, 1'b0, 8'h00);
        check_coin_counter(coin_counter, 2'b01, "coin_counter after second write");

        // Banked buffer under random video control values
        for (int round = 0; round < N_ROUNDS; round++) begin
            logic [31:0] r;
            r = next_random();
            write_vid_ctrl(r[15:0]);
            for (int w = 0; w < N_BUF_WR; w++) begin
                r = next_random();
                step_buffer(r[31], {r[30], 7'b0, r[2:0]}, 1'b1, r[23:8]);
            end
            for (int a = 0; a < N_BUF_RD; a++) begin
                step_buffer(a[0], {a[4], 7'b0, a[3:1]}, 1'b0, 16'h0000);
            end
        end

        step_io(port_switch_p1_p2, 1'b0, 8'h00);
        repeat (2) @(negedge clk_sys);
        $display("Test OK");
        $finish;
    end

endmodule

// ==== m92_io_buffer.f ====
+incdir+include
design/m92_board_pkg.sv
design/m92_video_pkg.sv
design/m92_io_ports.sv
design/buffer_bank_select.sv
design/buffer_bank.sv
design/buffer_read_mux.sv
design/m92_io_buffer.sv
testbench/tb_m92_io_buffer.sv
